// File: sources.f
+incdir+common
common/pwm_pkg.sv
rtl/apb_reg_decoder.sv
pwm_channel/pwm_channel.sv
rtl/apb_read_mux.sv
rtl/apb_pwm_top.sv
tests/pwm_checker.sv
tests/tb_apb_pwm.sv

// File: Makefile
# Verilator build and run of the APB PWM bank testbench

VERILATOR ?= verilator
TOP       ?= tb_apb_pwm
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/10ps
PASS_MSG  ?= SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator, run it, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: tests/tb_apb_pwm.sv
// Testbench top of the APB PWM bank, applying a table of channel settings over APB and reporting
`timescale 1ns/10ps
`include "pwm_config.svh"

module tb_apb_pwm;

  localparam int          NUM_ROWS       = 7;
  localparam int          TIMEOUT_CYCLES = NUM_ROWS * (2 * 257 + 20) + 200;
  localparam int unsigned RAND_SEED      = 41664;

  typedef struct packed {
    logic [`PWM_CH_SEL_WIDTH-1:0] ch;
    logic [`PWM_CTR_WIDTH-1:0]    period;
    logic [`PWM_CTR_WIDTH-1:0]    duty;
    logic                         en;
    logic [`PWM_CTR_WIDTH:0]      exp_high;  // High cycles per PERIOD+1 window
  } row_t;

  logic                         clk_sys;
  logic                         rst_sys_n;
  pwm_pkg::apb_req_t            apb_req;
  pwm_pkg::apb_rsp_t            apb_rsp;
  logic [`PWM_NUM_CHANNELS-1:0] pwm;
  logic                         meas_en;
  logic [`PWM_CH_SEL_WIDTH-1:0] meas_ch;
  logic [`PWM_CTR_WIDTH:0]      exp_high;
  int                           err_count;
  int                           check_count;
  int                           cycle_cnt;
  logic [`PWM_CH_SEL_WIDTH-1:0] rand_ch;
  row_t                         rows [NUM_ROWS];

  apb_pwm_top i_dut (
    .clk_sys_i (clk_sys),
    .rst_sys_ni(rst_sys_n),
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp),
    .pwm_o     (pwm)
  );

  pwm_checker i_checker (
    .clk_sys_i    (clk_sys),
    .rst_sys_ni   (rst_sys_n),
    .apb_req_i    (apb_req),
    .apb_rsp_i    (apb_rsp),
    .pwm_i        (pwm),
    .meas_en_i    (meas_en),
    .meas_ch_i    (meas_ch),
    .exp_high_i   (exp_high),
    .err_count_o  (err_count),
    .check_count_o(check_count)
  );

  always #4 clk_sys = ~clk_sys;  // 8 ns period

  always @(posedge clk_sys) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // APB driver and helpers
  ////////////////////////////////////////////////////////////////////////////

  // Bits 7:4 channel, bits 3:2 register slot
  function automatic logic [11:0] reg_addr(input logic [3:0] ch, input logic [1:0] slot);
    return {4'b0000, ch, slot, 2'b00};
  endfunction

  task automatic apb_transfer(input logic wr, input logic [11:0] addr, input logic [31:0] data);
    @(posedge clk_sys);
    #1;
    apb_req.psel    = 1'b1;  // Setup cycle
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    @(posedge clk_sys);
    #1;
    apb_req.penable = 1'b1;
    @(posedge clk_sys);
    while (!apb_rsp.pready) begin
      @(posedge clk_sys);
    end
    #1;
    apb_req = '0;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_sys);
  endtask

  // Opens the checker's window for len cycles on one channel
  task automatic measure_window(input logic [3:0] ch, input int len, input logic [8:0] exp);
    @(posedge clk_sys);
    #1;
    meas_ch  = ch;
    exp_high = exp;
    meas_en  = 1'b1;
    repeat (len) @(posedge clk_sys);
    #1;
    meas_en = 1'b0;
    @(posedge clk_sys);
  endtask

  task automatic read_settings(input logic [3:0] ch);
    apb_transfer(1'b0, reg_addr(ch, 2'd0), '0);
    apb_transfer(1'b0, reg_addr(ch, 2'd1), '0);
    apb_transfer(1'b0, reg_addr(ch, 2'd2), '0);
  endtask

  task automatic fill_table;
    rows[0] = '{4'd0,  8'd9,   8'd4,   1'b1, 9'd4};
    rows[1] = '{4'd1,  8'd15,  8'd0,   1'b1, 9'd0};    // Never high
    rows[2] = '{4'd2,  8'd7,   8'd20,  1'b1, 9'd8};    // Duty past the period
    rows[3] = '{4'd3,  8'd20,  8'd21,  1'b1, 9'd21};   // Always high
    rows[4] = '{4'd4,  8'd31,  8'd10,  1'b0, 9'd0};    // Disabled
    rows[5] = '{4'd5,  8'd255, 8'd128, 1'b1, 9'd128};
    rows[6] = '{4'd11, 8'd5,   8'd3,   1'b1, 9'd3};
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk_sys   = 1'b0;
    rst_sys_n = 1'b0;
    apb_req   = '0;
    meas_en   = 1'b0;
    meas_ch   = '0;
    exp_high  = '0;
    cycle_cnt = 0;
    void'($urandom(RAND_SEED));
    fill_table();
    repeat (16) @(posedge clk_sys);
    #1;
    rst_sys_n = 1'b1;

    for (int r = 0; r < NUM_ROWS; r++) begin
      apb_transfer(1'b1, reg_addr(rows[r].ch, 2'd1), {24'b0, rows[r].period});
      apb_transfer(1'b1, reg_addr(rows[r].ch, 2'd2), {24'b0, rows[r].duty});
      apb_transfer(1'b1, reg_addr(rows[r].ch, 2'd0), {31'b0, rows[r].en});
      wait_cycles(int'(rows[r].period) + 1);  // First window lets the settings land
      measure_window(rows[r].ch, int'(rows[r].period) + 1, rows[r].exp_high);
      read_settings(rows[r].ch);
      if (!rows[r].en) begin
        apb_transfer(1'b0, reg_addr(rows[r].ch, 2'd3), '0);
      end
    end

    // Illegal accesses, then readback of what they would have hit
    apb_transfer(1'b1, reg_addr(4'd12, 2'd1), 32'h33);
    apb_transfer(1'b0, reg_addr(4'd15, 2'd2), '0);
    apb_transfer(1'b1, reg_addr(4'd0, 2'd3), 32'h11);
    apb_transfer(1'b1, reg_addr(4'd0, 2'd1) | 12'h100, 32'h77);
    apb_transfer(1'b0, reg_addr(4'd0, 2'd1) | 12'h800, '0);
    read_settings(4'd0);

    // Channels 6 to 10 are never written by the table
    repeat (4) begin
      rand_ch = 4'(6 + $urandom % 5);
      apb_transfer(1'b0, reg_addr(rand_ch, 2'($urandom % 4)), '0);
    end

    rand_ch = 4'(6 + $urandom % 5);
    apb_transfer(1'b1, reg_addr(rand_ch, 2'd1), 32'd50);
    apb_transfer(1'b1, reg_addr(rand_ch, 2'd2), 32'd25);
    apb_transfer(1'b1, reg_addr(rand_ch, 2'd0), 32'd1);
    wait_cycles(51);
    measure_window(rand_ch, 51, 9'd25);
    for (int r = 0; r < NUM_ROWS; r++) begin
      measure_window(rows[r].ch, int'(rows[r].period) + 1, rows[r].exp_high);
      read_settings(rows[r].ch);
    end

    $display("Checker finished with %0d checks and %0d errors", check_count, err_count);
    if (err_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: tests/pwm_checker.sv
// Testbench checker that shadows the PWM registers from APB traffic and scores reads, pslverr and duty
`timescale 1ns/10ps
`include "pwm_config.svh"

module pwm_checker (
  input  logic                         clk_sys_i,
  input  logic                         rst_sys_ni,
  input  pwm_pkg::apb_req_t            apb_req_i,
  input  pwm_pkg::apb_rsp_t            apb_rsp_i,
  input  logic [`PWM_NUM_CHANNELS-1:0] pwm_i,

  // Measuring window, opened by the stimulus side
  input  logic                         meas_en_i,
  input  logic [`PWM_CH_SEL_WIDTH-1:0] meas_ch_i,
  input  logic [`PWM_CTR_WIDTH:0]      exp_high_i,

  output int                           err_count_o,
  output int                           check_count_o
);

  logic                         en_sh   [`PWM_NUM_CHANNELS];
  logic [`PWM_CTR_WIDTH-1:0]    per_sh  [`PWM_NUM_CHANNELS];
  logic [`PWM_CTR_WIDTH-1:0]    duty_sh [`PWM_NUM_CHANNELS];
  logic [`PWM_CH_SEL_WIDTH-1:0] acc_ch;
  logic [1:0]                   acc_slot;
  logic                         addr_err;
  logic                         check_rd;
  logic [`APB_DATA_WIDTH-1:0]   exp_rd;
  logic                         meas_q;
  int                           high_cnt;
  int                           exp_high;
  int                           err_count = 0;
  int                           check_count = 0;

  // High cycles in any PERIOD+1 window with steady settings
  function automatic int high_per_window(input logic en, input logic [`PWM_CTR_WIDTH-1:0] period,
                                         input logic [`PWM_CTR_WIDTH-1:0] duty);
    int full;
    full = int'(period) + 1;
    if (!en) begin
      return 0;
    end
    return (int'(duty) < full) ? int'(duty) : full;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (exp !== act) begin
      err_count++;
      $display("** Error at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Scoring, mid-cycle where bus and outputs are settled
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_sys_i) begin
    if (!rst_sys_ni) begin
      for (int i = 0; i < `PWM_NUM_CHANNELS; i++) begin
        en_sh[i]   = 1'b0;
        per_sh[i]  = '0;
        duty_sh[i] = '0;
      end
      high_cnt = 0;
      meas_q   = 1'b0;
    end else begin
      acc_ch   = apb_req_i.paddr[7:4];
      acc_slot = apb_req_i.paddr[3:2];
      addr_err = (int'(acc_ch) >= `PWM_NUM_CHANNELS) || (apb_req_i.pwrite && acc_slot == 2'd3) ||
                 (|apb_req_i.paddr[11:8]);

      if (apb_req_i.psel && apb_req_i.penable) begin  // Access cycle
        compare_value("pready", 32'd1, {31'b0, apb_rsp_i.pready});
        compare_value("pslverr", {31'b0, addr_err}, {31'b0, apb_rsp_i.pslverr});
        if (!apb_req_i.pwrite) begin
          exp_rd   = '0;
          check_rd = 1'b1;
          if (!addr_err) begin
            case (acc_slot)
              pwm_pkg::REG_CTRL:   exp_rd = {31'b0, en_sh[acc_ch]};
              pwm_pkg::REG_PERIOD: exp_rd = {24'b0, per_sh[acc_ch]};
              pwm_pkg::REG_DUTY:   exp_rd = {24'b0, duty_sh[acc_ch]};
              default:             check_rd = !en_sh[acc_ch];  // COUNT known only while held
            endcase
          end
          if (check_rd) begin
            compare_value("prdata", exp_rd, apb_rsp_i.prdata);
          end
        end else if (!addr_err) begin
          case (acc_slot)
            pwm_pkg::REG_CTRL:   en_sh[acc_ch]   = apb_req_i.pwdata[0];
            pwm_pkg::REG_PERIOD: per_sh[acc_ch]  = apb_req_i.pwdata[7:0];
            pwm_pkg::REG_DUTY:   duty_sh[acc_ch] = apb_req_i.pwdata[7:0];
            default: ;
          endcase
        end
      end else if (apb_rsp_i.pslverr) begin
        err_count++;
        $display("pslverr was raised at %0t outside an access cycle", $time);
      end

      // Duty window
      if (meas_en_i) begin
        if (!meas_q) begin
          high_cnt = 0;
        end
        if (pwm_i[meas_ch_i]) begin
          high_cnt++;
        end
      end else if (meas_q) begin
        exp_high = high_per_window(en_sh[meas_ch_i], per_sh[meas_ch_i], duty_sh[meas_ch_i]);
        if (exp_high != int'(exp_high_i)) begin
          err_count++;
          $display("Stimulus table expects %0d high cycles on channel %0d, register model gives %0d",
                   exp_high_i, meas_ch_i, exp_high);
        end
        compare_value($sformatf("pwm_o[%0d] high count", meas_ch_i), exp_high, high_cnt);
      end
      meas_q = meas_en_i;
    end
  end

  assign err_count_o   = err_count;
  assign check_count_o = check_count;

endmodule

// File: rtl/apb_pwm_top.sv
// Top level of the APB PWM bank, connecting the register decoder, the channels and the read mux
`timescale 1ns/10ps
`include "pwm_config.svh"

module apb_pwm_top (
  input  logic                         clk_sys_i,
  input  logic                         rst_sys_ni,

  // APB3 slave port
  input  pwm_pkg::apb_req_t            apb_req_i,
  output pwm_pkg::apb_rsp_t            apb_rsp_o,

  // One output per channel
  output logic [`PWM_NUM_CHANNELS-1:0] pwm_o
);

  pwm_pkg::pwm_wr_t    [`PWM_NUM_CHANNELS-1:0] ch_wr;
  pwm_pkg::pwm_state_t [`PWM_NUM_CHANNELS-1:0] ch_state;
  logic                [`PWM_NUM_CHANNELS-1:0] rd_sel;
  pwm_pkg::pwm_reg_e                           rd_reg;
  logic                [`APB_DATA_WIDTH-1:0]   prdata;
  logic                                        pslverr;

  ////////////////////////////////////////////////////////////////////////////
  // Address decode and legality
  ////////////////////////////////////////////////////////////////////////////

  apb_reg_decoder u_decoder (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_ni),
    .apb_req_i (apb_req_i),
    .ch_wr_o   (ch_wr),
    .rd_sel_o  (rd_sel),
    .rd_reg_o  (rd_reg),
    .pslverr_o (pslverr)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Channel bank
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `PWM_NUM_CHANNELS; i++) begin : gen_channel
    pwm_channel u_channel (
      .clk_sys_i (clk_sys_i),
      .rst_sys_ni(rst_sys_ni),
      .wr_i      (ch_wr[i]),
      .state_o   (ch_state[i]),
      .pwm_o     (pwm_o[i])
    );
  end : gen_channel

  ////////////////////////////////////////////////////////////////////////////
  // Readback and response
  ////////////////////////////////////////////////////////////////////////////

  apb_read_mux u_read_mux (
    .state_i  (ch_state),
    .rd_sel_i (rd_sel),
    .rd_reg_i (rd_reg),
    .prdata_o (prdata)
  );

  assign apb_rsp_o.prdata  = prdata;
  assign apb_rsp_o.pready  = 1'b1;   // Every transfer completes in its access cycle
  assign apb_rsp_o.pslverr = pslverr;

endmodule

// File: rtl/apb_read_mux.sv
// Read data mux of the PWM bank, returning the addressed channel register as APB prdata
`timescale 1ns/10ps
`include "pwm_config.svh"

module apb_read_mux (
  input  pwm_pkg::pwm_state_t [`PWM_NUM_CHANNELS-1:0] state_i,
  input  logic                [`PWM_NUM_CHANNELS-1:0] rd_sel_i,  // One-hot or zero
  input  pwm_pkg::pwm_reg_e                           rd_reg_i,
  output logic                [`APB_DATA_WIDTH-1:0]   prdata_o
);

  pwm_pkg::pwm_state_t sel_state;

  // AND-OR select, zero when nothing is selected
  always_comb begin
    sel_state = '0;
    for (int i = 0; i < `PWM_NUM_CHANNELS; i++) begin
      if (rd_sel_i[i]) begin
        sel_state = sel_state | state_i[i];
      end
    end
  end

  // Field pick, zero-extended to the bus width
  always_comb begin
    case (rd_reg_i)
      pwm_pkg::REG_CTRL:   prdata_o = `APB_DATA_WIDTH'(sel_state.enable);
      pwm_pkg::REG_PERIOD: prdata_o = `APB_DATA_WIDTH'(sel_state.period);
      pwm_pkg::REG_DUTY:   prdata_o = `APB_DATA_WIDTH'(sel_state.duty);
      pwm_pkg::REG_COUNT:  prdata_o = `APB_DATA_WIDTH'(sel_state.count);
      default:             prdata_o = '0;
    endcase
  end

endmodule

// File: pwm_channel/pwm_channel.sv
// One PWM channel with CTRL, PERIOD and DUTY registers, a wrapping counter and a registered output
`timescale 1ns/10ps
`include "pwm_config.svh"

module pwm_channel (
  input  logic                clk_sys_i,
  input  logic                rst_sys_ni,

  input  pwm_pkg::pwm_wr_t    wr_i,      // From the decoder
  output pwm_pkg::pwm_state_t state_o,   // To the read mux

  output logic                pwm_o
);

  logic                      enable_q;
  logic [`PWM_CTR_WIDTH-1:0] period_q;
  logic [`PWM_CTR_WIDTH-1:0] duty_q;
  logic [`PWM_CTR_WIDTH-1:0] count_q;
  logic                      pwm_q;
  logic                      wrap;

  ////////////////////////////////////////////////////////////////////////////
  // Control registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      enable_q <= 1'b0;
      period_q <= '0;
      duty_q   <= '0;
    end else if (wr_i.wr_en) begin
      case (wr_i.reg_sel)
        pwm_pkg::REG_CTRL:   enable_q <= wr_i.wdata[0];
        pwm_pkg::REG_PERIOD: period_q <= wr_i.wdata;
        pwm_pkg::REG_DUTY:   duty_q   <= wr_i.wdata;
        default: ;  // COUNT is read only
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Counter and compare
  ////////////////////////////////////////////////////////////////////////////

  // At or past PERIOD also covers a PERIOD lowered mid-cycle
  assign wrap = count_q >= period_q;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      count_q <= '0;
    end else if (!enable_q) begin
      count_q <= '0;             // Held while disabled
    end else if (wrap) begin
      count_q <= '0;
    end else begin
      count_q <= count_q + 1'b1;
    end
  end

  // High for count values 0 .. DUTY-1 of each PERIOD+1 cycle
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      pwm_q <= 1'b0;
    end else begin
      pwm_q <= enable_q & (count_q < duty_q);
    end
  end

  assign pwm_o = pwm_q;

  assign state_o.enable = enable_q;
  assign state_o.period = period_q;
  assign state_o.duty   = duty_q;
  assign state_o.count  = count_q;

endmodule

// File: rtl/apb_reg_decoder.sv
// APB access decoder for the PWM bank, producing channel write commands, read select and pslverr
`timescale 1ns/10ps
`include "pwm_config.svh"

module apb_reg_decoder (
  input  logic                                     clk_sys_i,
  input  logic                                     rst_sys_ni,

  input  pwm_pkg::apb_req_t                        apb_req_i,

  // To the channels
  output pwm_pkg::pwm_wr_t [`PWM_NUM_CHANNELS-1:0] ch_wr_o,

  // To the read mux
  output logic             [`PWM_NUM_CHANNELS-1:0] rd_sel_o,
  output pwm_pkg::pwm_reg_e                        rd_reg_o,

  output logic                                     pslverr_o
);

  logic [`PWM_CH_SEL_WIDTH-1:0] ch_idx;
  pwm_pkg::pwm_reg_e            reg_slot;
  logic                         setup_q;
  logic                         access;
  logic                         ch_out_of_range;
  logic                         wr_read_only;
  logic                         addr_high_set;
  logic                         addr_err;
  logic                         legal_wr;
  logic                         legal_rd;

  ////////////////////////////////////////////////////////////////////////////
  // Transfer phase tracking
  ////////////////////////////////////////////////////////////////////////////

  // Remembers that the previous cycle was a setup phase
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      setup_q <= 1'b0;
    end else begin
      setup_q <= apb_req_i.psel & ~apb_req_i.penable;
    end
  end

  // Access phase only when it follows a setup phase
  assign access = apb_req_i.psel & apb_req_i.penable & setup_q;

  ////////////////////////////////////////////////////////////////////////////
  // Address split and legality
  ////////////////////////////////////////////////////////////////////////////

  assign ch_idx   = apb_req_i.paddr[`PWM_CH_STRIDE_BITS +: `PWM_CH_SEL_WIDTH];
  assign reg_slot = pwm_pkg::pwm_reg_e'(apb_req_i.paddr[`PWM_REG_IDX_LSB +: `PWM_REG_IDX_WIDTH]);

  assign ch_out_of_range = int'(ch_idx) >= `PWM_NUM_CHANNELS;
  assign wr_read_only    = apb_req_i.pwrite & (reg_slot == pwm_pkg::REG_COUNT);
  assign addr_high_set   = |apb_req_i.paddr[`APB_ADDR_WIDTH-1:`PWM_DEV_ADDR_WIDTH];
  assign addr_err        = ch_out_of_range | wr_read_only | addr_high_set;

  assign legal_wr = access & apb_req_i.pwrite & ~addr_err;
  assign legal_rd = access & ~apb_req_i.pwrite & ~addr_err;

  assign pslverr_o = access & addr_err;  // Low outside the access phase
  assign rd_reg_o  = reg_slot;

  ////////////////////////////////////////////////////////////////////////////
  // Per-channel strobes
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < `PWM_NUM_CHANNELS; i++) begin
      ch_wr_o[i].wr_en   = legal_wr && (int'(ch_idx) == i);
      ch_wr_o[i].reg_sel = reg_slot;
      ch_wr_o[i].wdata   = apb_req_i.pwdata[`PWM_CTR_WIDTH-1:0];
      rd_sel_o[i]        = legal_rd && (int'(ch_idx) == i);  // One-hot or zero
    end
  end

endmodule

// File: common/pwm_pkg.sv
// Shared APB and PWM channel types of the PWM bank, referenced by scoped name where used
`include "pwm_config.svh"

package pwm_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // APB3 request and response
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [`APB_ADDR_WIDTH-1:0] paddr;
    logic [`APB_DATA_WIDTH-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [`APB_DATA_WIDTH-1:0] prdata;
    logic                       pready;   // Tied high, no wait states
    logic                       pslverr;
  } apb_rsp_t;

  ////////////////////////////////////////////////////////////////////////////
  // Per-channel register slots and traffic
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [`PWM_REG_IDX_WIDTH-1:0] {
    REG_CTRL   = 2'd0,
    REG_PERIOD = 2'd1,
    REG_DUTY   = 2'd2,
    REG_COUNT  = 2'd3   // Read only
  } pwm_reg_e;

  // Write command from the decoder to one channel
  typedef struct packed {
    logic                      wr_en;
    pwm_reg_e                  reg_sel;
    logic [`PWM_CTR_WIDTH-1:0] wdata;
  } pwm_wr_t;

  // Everything a channel exposes for readback
  typedef struct packed {
    logic                      enable;
    logic [`PWM_CTR_WIDTH-1:0] period;
    logic [`PWM_CTR_WIDTH-1:0] duty;
    logic [`PWM_CTR_WIDTH-1:0] count;
  } pwm_state_t;

endpackage

// File: common/pwm_config.svh
// Build-time sizing and register map of the APB PWM bank, included by the package and RTL
`ifndef PWM_CONFIG_SVH
`define PWM_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Channel sizing
////////////////////////////////////////////////////////////////////////////

`define PWM_NUM_CHANNELS   12  // Also the width of pwm_o
`define PWM_CTR_WIDTH      8   // Counter, PERIOD and DUTY

////////////////////////////////////////////////////////////////////////////
// APB bus and register map
////////////////////////////////////////////////////////////////////////////

`define APB_ADDR_WIDTH     12
`define APB_DATA_WIDTH     32

// Register slot sits in paddr[3:2] and the channel index in paddr[7:4]
`define PWM_REG_IDX_LSB    2
`define PWM_REG_IDX_WIDTH  2
`define PWM_CH_STRIDE_BITS 4
`define PWM_CH_SEL_WIDTH   4
`define PWM_DEV_ADDR_WIDTH (`PWM_CH_STRIDE_BITS + `PWM_CH_SEL_WIDTH)  // Bits above are illegal

`endif
